// File: include/aes_sbox_table.svh
////////////////////
// Forward AES S-box as a lookup function
// Meant to be included inside a module body
// Combinational only, no inverse table
////////////////////
`ifndef AES_SBOX_TABLE_SVH
`define AES_SBOX_TABLE_SVH

// Forward S-box lookup
function automatic logic [7:0] aes_sbox_fwd(input logic [7:0] in);
  logic [0:255][7:0] lut;
  // One row per high nibble, entry 0 in the upper bits
  lut = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };
  return lut[in];
endfunction

`endif

// File: rtl/aes_key_pkg.sv
////////////////////
// Types, sizes and GF(2^8) helpers for the key expansion pipeline
// Only AES-128 and AES-256 are covered
// Byte 0 of a word sits in bits 7:0
////////////////////
`default_nettype none

package aes_key_pkg;

  ////////////////////
  // Enums
  ////////////////////

  // Direction of one schedule step
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Key length
  typedef enum logic {
    AES_128 = 1'b0,
    AES_256 = 1'b1
  } key_len_e;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int NumKeyWords = 8;
  localparam int WordWidth   = 32;
  localparam int RoundWidth  = 4;

  // Key window, word 0 lowest
  typedef logic [NumKeyWords-1:0][WordWidth-1:0] key_win_t;

  // Rcon start values
  localparam logic [7:0] RconFwdInit    = 8'h01;
  localparam logic [7:0] RconInv128Init = 8'h36;
  localparam logic [7:0] RconInv256Init = 8'h40;

  ////////////////////
  // Helpers
  ////////////////////

  // Multiply by x, reduce with 0x11B
  function automatic logic [7:0] aes_mul2(input logic [7:0] in);
    return {in[6:0], 1'b0} ^ (in[7] ? 8'h1b : 8'h00);
  endfunction

  // Divide by x
  // 0x8d is 0x11B shifted right by one
  function automatic logic [7:0] aes_div2(input logic [7:0] in);
    return {1'b0, in[7:1]} ^ (in[0] ? 8'h8d : 8'h00);
  endfunction

  // RotWord, byte 0 ends up in byte 3
  function automatic logic [WordWidth-1:0] aes_rot_word(input logic [WordWidth-1:0] in);
    return {in[7:0], in[WordWidth-1:8]};
  endfunction

endpackage

`default_nettype wire

// File: rtl/key_expand_decode.sv
////////////////////
// Stage 1 of the key schedule pipeline
// clear_i must not coincide with valid_i
// Rcon advances only on accepted requests that use it
////////////////////
`default_nettype none

module key_expand_decode import aes_key_pkg::*; #(
  parameter bit AES256Enable = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  valid_i,
  input  ciph_op_e              op_i,
  input  key_len_e              key_len_i,
  input  logic [RoundWidth-1:0] round_i,
  input  key_win_t              key_i,
  output logic                  ready_o,
  output logic                  valid_o,
  output ciph_op_e              op_o,
  output key_len_e              key_len_o,
  output logic [RoundWidth-1:0] round_o,
  output key_win_t              key_o,
  output logic [WordWidth-1:0]  rot_in_o,
  output logic                  use_rot_word_o,
  output logic                  use_rcon_o,
  output logic [7:0]            rcon_o,
  input  logic                  ready_i
);

  key_len_e             key_len;
  logic                 accept;
  logic                 use_rot_word;
  logic                 use_rcon;
  logic [WordWidth-1:0] rot_in;
  logic [7:0]           rcon_q;
  logic [7:0]           rcon_d;
  logic [7:0]           rcon_init;
  logic                 rcon_we;

  // Without AES-256 support every request is AES-128
  assign key_len = AES256Enable ? key_len_i : AES_128;

  // Register free or draining this cycle
  assign ready_o = ~valid_o | ready_i;
  assign accept  = valid_i & ready_o;

  ////////////////////
  // Control flags
  ////////////////////

  // AES-256 uses RotWord and Rcon in odd rounds only
  assign use_rot_word = (key_len == AES_256) ? round_i[0] : 1'b1;
  assign use_rcon     = use_rot_word;

  // RotWord input word
  always_comb begin
    if (key_len == AES_256) begin
      rot_in = (op_i == CIPH_FWD) ? key_i[7] : key_i[3];
    end else begin
      // Inverse AES-128 rebuilds word 3 of the previous key from k3 and k2
      rot_in = (op_i == CIPH_FWD) ? key_i[3] : key_i[3] ^ key_i[2];
    end
  end

  ////////////////////
  // Rcon register
  ////////////////////

  // Start value by direction and key length
  always_comb begin
    if (op_i == CIPH_FWD) begin
      rcon_init = RconFwdInit;
    end else begin
      rcon_init = (key_len == AES_256) ? RconInv256Init : RconInv128Init;
    end
  end

  assign rcon_d  = clear_i ? rcon_init :
                   (op_i == CIPH_FWD) ? aes_mul2(rcon_q) : aes_div2(rcon_q);
  assign rcon_we = clear_i | (accept & use_rcon);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rcon_q <= 8'h00;
    end else if (rcon_we) begin
      rcon_q <= rcon_d;
    end
  end

  ////////////////////
  // Pipeline register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end
  end

  // Payload, item carries Rcon before the update
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_o           <= op_i;
      key_len_o      <= key_len;
      round_o        <= round_i;
      key_o          <= key_i;
      rot_in_o       <= rot_in;
      use_rot_word_o <= use_rot_word;
      use_rcon_o     <= use_rcon;
      rcon_o         <= rcon_q;
    end
  end

  // Request selectors known
  a_sel_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> !$isunknown({op_i, key_len_i}));

  // Clear never overlaps a request
  a_clear_no_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(clear_i && valid_i));

endmodule

`default_nettype wire

// File: rtl/key_expand_execute.sv
////////////////////
// Stage 2 of the key schedule pipeline
// RotWord, SubWord and Rcon add on the selected word
////////////////////
`default_nettype none

module key_expand_execute import aes_key_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  valid_i,
  output logic                  ready_o,
  input  ciph_op_e              op_i,
  input  key_len_e              key_len_i,
  input  logic [RoundWidth-1:0] round_i,
  input  key_win_t              key_i,
  input  logic [WordWidth-1:0]  rot_in_i,
  input  logic                  use_rot_word_i,
  input  logic                  use_rcon_i,
  input  logic [7:0]            rcon_i,
  output logic                  valid_o,
  output ciph_op_e              op_o,
  output key_len_e              key_len_o,
  output logic [RoundWidth-1:0] round_o,
  output key_win_t              key_o,
  output logic [WordWidth-1:0]  irregular_o,
  input  logic                  ready_i
);

  `include "aes_sbox_table.svh"

  logic                 accept;
  logic [WordWidth-1:0] sub_in;
  logic [WordWidth-1:0] sub_out;
  logic [WordWidth-1:0] irregular;

  assign ready_o = ~valid_o | ready_i;
  assign accept  = valid_i & ready_o;

  ////////////////////
  // Irregular word
  ////////////////////

  always_comb begin
    sub_in = use_rot_word_i ? aes_rot_word(rot_in_i) : rot_in_i;
    // SubWord, one lookup per byte
    for (int b = 0; b < 4; b++) begin
      sub_out[8*b +: 8] = aes_sbox_fwd(sub_in[8*b +: 8]);
    end
    irregular = sub_out;
    // Rcon only touches byte 0
    if (use_rcon_i) begin
      irregular[7:0] = sub_out[7:0] ^ rcon_i;
    end
  end

  ////////////////////
  // Pipeline register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_o        <= op_i;
      key_len_o   <= key_len_i;
      round_o     <= round_i;
      key_o       <= key_i;
      irregular_o <= irregular;
    end
  end

endmodule

`default_nettype wire

// File: rtl/key_expand_result.sv
////////////////////
// Stage 3 of the key schedule pipeline
// Chains words into the output window
// Output holds until ready_i is seen
////////////////////
`default_nettype none

module key_expand_result import aes_key_pkg::*; #(
  parameter bit AES256Enable = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  valid_i,
  output logic                  ready_o,
  input  ciph_op_e              op_i,
  input  key_len_e              key_len_i,
  input  logic [RoundWidth-1:0] round_i,
  input  key_win_t              key_i,
  input  logic [WordWidth-1:0]  irregular_i,
  output logic                  valid_o,
  output key_win_t              key_o,
  input  logic                  ready_i
);

  logic     accept;
  key_win_t next_key;

  assign ready_o = ~valid_o | ready_i;
  assign accept  = valid_i & ready_o;

  ////////////////////
  // Word chaining
  ////////////////////

  always_comb begin
    // Halves swapped, kept for AES-256 round 0
    next_key = {key_i[3:0], key_i[7:4]};
    if (AES256Enable && (key_len_i == AES_256)) begin
      if (round_i != '0) begin
        if (op_i == CIPH_FWD) begin
          // Old upper half moves down
          next_key[3:0] = key_i[7:4];
          next_key[4]   = irregular_i ^ key_i[0];
          for (int i = 1; i < 4; i++) begin
            next_key[i+4] = next_key[i+3] ^ key_i[i];
          end
        end else begin
          // Old lower half moves up
          next_key[7:4] = key_i[3:0];
          next_key[0]   = irregular_i ^ key_i[4];
          for (int i = 0; i < 3; i++) begin
            next_key[i+1] = key_i[4+i] ^ key_i[5+i];
          end
        end
      end
    end else begin
      // AES-128, upper words just keep the old key
      next_key[7:4] = key_i[3:0];
      next_key[0]   = irregular_i ^ key_i[0];
      for (int i = 1; i < 4; i++) begin
        if (op_i == CIPH_FWD) begin
          next_key[i] = next_key[i-1] ^ key_i[i];
        end else begin
          next_key[i] = key_i[i-1] ^ key_i[i];
        end
      end
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      key_o <= next_key;
    end
  end

  // Stalled result stays put until taken
  a_hold_until_ready : assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(key_o));

endmodule

`default_nettype wire

// File: rtl/aes_key_expand_top.sv
////////////////////
// AES key expansion, one schedule step per request
// Three stages, result three edges after acceptance
// AES256Enable = 0 treats all requests as AES-128
////////////////////
`default_nettype none

module aes_key_expand_top import aes_key_pkg::*; #(
  parameter bit AES256Enable = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  valid_i,
  input  ciph_op_e              op_i,
  input  key_len_e              key_len_i,
  input  logic [RoundWidth-1:0] round_i,
  input  key_win_t              key_i,
  output logic                  ready_o,
  output logic                  valid_o,
  input  logic                  ready_i,
  output key_win_t              key_o
);

  // Decode to execute
  logic                  d2e_valid;
  logic                  d2e_ready;
  ciph_op_e              d2e_op;
  key_len_e              d2e_key_len;
  logic [RoundWidth-1:0] d2e_round;
  key_win_t              d2e_key;
  logic [WordWidth-1:0]  d2e_rot_in;
  logic                  d2e_use_rot_word;
  logic                  d2e_use_rcon;
  logic [7:0]            d2e_rcon;

  // Execute to result
  logic                  e2r_valid;
  logic                  e2r_ready;
  ciph_op_e              e2r_op;
  key_len_e              e2r_key_len;
  logic [RoundWidth-1:0] e2r_round;
  key_win_t              e2r_key;
  logic [WordWidth-1:0]  e2r_irregular;

  key_expand_decode #(
    .AES256Enable ( AES256Enable )
  ) key_expand_decode_i (
    .clk_i          ( clk_i            ),
    .rst_ni         ( rst_ni           ),
    .clear_i        ( clear_i          ),
    .valid_i        ( valid_i          ),
    .op_i           ( op_i             ),
    .key_len_i      ( key_len_i        ),
    .round_i        ( round_i          ),
    .key_i          ( key_i            ),
    .ready_o        ( ready_o          ),
    .valid_o        ( d2e_valid        ),
    .op_o           ( d2e_op           ),
    .key_len_o      ( d2e_key_len      ),
    .round_o        ( d2e_round        ),
    .key_o          ( d2e_key          ),
    .rot_in_o       ( d2e_rot_in       ),
    .use_rot_word_o ( d2e_use_rot_word ),
    .use_rcon_o     ( d2e_use_rcon     ),
    .rcon_o         ( d2e_rcon         ),
    .ready_i        ( d2e_ready        )
  );

  key_expand_execute key_expand_execute_i (
    .clk_i          ( clk_i            ),
    .rst_ni         ( rst_ni           ),
    .valid_i        ( d2e_valid        ),
    .ready_o        ( d2e_ready        ),
    .op_i           ( d2e_op           ),
    .key_len_i      ( d2e_key_len      ),
    .round_i        ( d2e_round        ),
    .key_i          ( d2e_key          ),
    .rot_in_i       ( d2e_rot_in       ),
    .use_rot_word_i ( d2e_use_rot_word ),
    .use_rcon_i     ( d2e_use_rcon     ),
    .rcon_i         ( d2e_rcon         ),
    .valid_o        ( e2r_valid        ),
    .op_o           ( e2r_op           ),
    .key_len_o      ( e2r_key_len      ),
    .round_o        ( e2r_round        ),
    .key_o          ( e2r_key          ),
    .irregular_o    ( e2r_irregular    ),
    .ready_i        ( e2r_ready        )
  );

  key_expand_result #(
    .AES256Enable ( AES256Enable )
  ) key_expand_result_i (
    .clk_i       ( clk_i         ),
    .rst_ni      ( rst_ni        ),
    .valid_i     ( e2r_valid     ),
    .ready_o     ( e2r_ready     ),
    .op_i        ( e2r_op        ),
    .key_len_i   ( e2r_key_len   ),
    .round_i     ( e2r_round     ),
    .key_i       ( e2r_key       ),
    .irregular_i ( e2r_irregular ),
    .valid_o     ( valid_o       ),
    .key_o       ( key_o         ),
    .ready_i     ( ready_i       )
  );

endmodule

`default_nettype wire

// File: test/key_expand_checker.sv
////////////////////
// Scoreboard for the key expansion outputs
// Expected windows come from the stimulus file, in order
////////////////////
`default_nettype none

module key_expand_checker import aes_key_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     valid_i,
  input  logic     ready_i,
  input  key_win_t key_i,
  output int       mismatch_count_o,
  output int       seq_error_count_o,
  output int       pending_o
);

  localparam string StimFile = "test/key_expand_stimulus.txt";

  key_win_t exp_q[$];

  // FIPS word order and byte order into the packed window
  function automatic key_win_t fips_to_window(input logic [255:0] raw);
    key_win_t    win;
    logic [31:0] w;
    for (int i = 0; i < 8; i++) begin
      w = raw[255-32*i -: 32];
      win[i] = {w[7:0], w[15:8], w[23:16], w[31:24]};
    end
    return win;
  endfunction

  task automatic load_expected();
    int           fd;
    int           n;
    string        line;
    logic [3:0]   clr;
    logic [3:0]   op;
    logic [3:0]   len;
    logic [3:0]   rnd;
    logic [255:0] key;
    logic [255:0] exp_win;
    fd = $fopen(StimFile, "r");
    if (fd == 0) begin
      $display("ERROR: checker cannot open stimulus file %s", StimFile);
      seq_error_count_o++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h", clr, op, len, rnd, key, exp_win);
        // Clear lines produce no output
        if (n == 6 && clr[0] == 1'b0) begin
          exp_q.push_back(fips_to_window(exp_win));
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    mismatch_count_o  = 0;
    seq_error_count_o = 0;
    load_expected();
    pending_o = exp_q.size();
  end

  // Sample mid-cycle where valid, ready and data are settled
  always @(negedge clk_i) begin
    key_win_t expected;
    if (rst_ni && valid_i && ready_i) begin
      if (exp_q.size() == 0) begin
        $display("ERROR at time %0t: output handshake with no request outstanding", $time);
        seq_error_count_o++;
      end else begin
        expected = exp_q.pop_front();
        pending_o = exp_q.size();
        if (key_i !== expected) begin
          $display("MISMATCH at time %0t: key_o expected %h actual %h", $time,
                   expected, key_i);
          mismatch_count_o++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: test/tb_key_expand.sv
////////////////////
// Testbench for the AES key expansion pipeline
// Run from the project root, stimulus path is relative to it
// Stimulus keys are in FIPS-197 word order, converted here
////////////////////
`default_nettype none

module tb_key_expand import aes_key_pkg::*; ();

  localparam string StimFile = "test/key_expand_stimulus.txt";

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  clear_i;
  logic                  valid_i;
  ciph_op_e              op_i;
  key_len_e              key_len_i;
  logic [RoundWidth-1:0] round_i;
  key_win_t              key_i;
  logic                  ready_o;
  logic                  valid_o;
  logic                  ready_i = 1'b0;
  key_win_t              key_o;

  // Parsed stimulus lines, clears included
  bit                    clr_q[$];
  bit                    op_q[$];
  bit                    len_q[$];
  logic [RoundWidth-1:0] rnd_q[$];
  logic [255:0]          key_q[$];

  logic [31:0] lfsr_q;
  bit          loaded;
  int          other_errors;
  int          mismatches;
  int          seq_errors;
  int          pending;

  always #20 clk_i = ~clk_i;

  aes_key_expand_top #(
    .AES256Enable ( 1'b1 )
  ) aes_key_expand_top_i (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .clear_i   ( clear_i   ),
    .valid_i   ( valid_i   ),
    .op_i      ( op_i      ),
    .key_len_i ( key_len_i ),
    .round_i   ( round_i   ),
    .key_i     ( key_i     ),
    .ready_o   ( ready_o   ),
    .valid_o   ( valid_o   ),
    .ready_i   ( ready_i   ),
    .key_o     ( key_o     )
  );

  key_expand_checker key_expand_checker_i (
    .clk_i             ( clk_i      ),
    .rst_ni            ( rst_ni     ),
    .valid_i           ( valid_o    ),
    .ready_i           ( ready_i    ),
    .key_i             ( key_o      ),
    .mismatch_count_o  ( mismatches ),
    .seq_error_count_o ( seq_errors ),
    .pending_o         ( pending    )
  );

  ////////////////////
  // Helpers
  ////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_next_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // FIPS word order and byte order into the packed window
  function automatic key_win_t fips_to_window(input logic [255:0] raw);
    key_win_t    win;
    logic [31:0] w;
    for (int i = 0; i < 8; i++) begin
      w = raw[255-32*i -: 32];
      win[i] = {w[7:0], w[15:8], w[23:16], w[31:24]};
    end
    return win;
  endfunction

  task automatic read_stimulus();
    int           fd;
    int           n;
    string        line;
    logic [3:0]   clr;
    logic [3:0]   op;
    logic [3:0]   len;
    logic [3:0]   rnd;
    logic [255:0] key;
    logic [255:0] exp_win;
    fd = $fopen(StimFile, "r");
    if (fd == 0) begin
      $display("ERROR: cannot open stimulus file %s", StimFile);
      other_errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // Skip blank and comment lines
      if (n > 1 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h", clr, op, len, rnd, key, exp_win);
        if (n == 6) begin
          clr_q.push_back(clr[0]);
          op_q.push_back(op[0]);
          len_q.push_back(len[0]);
          rnd_q.push_back(rnd);
          key_q.push_back(key);
        end
      end
    end
    $fclose(fd);
  endtask

  // Hold valid until the handshake, ready_o sampled mid-cycle
  task automatic send_request(input int idx);
    bit taken;
    valid_i   = 1'b1;
    op_i      = ciph_op_e'(op_q[idx]);
    key_len_i = key_len_e'(len_q[idx]);
    round_i   = rnd_q[idx];
    key_i     = fips_to_window(key_q[idx]);
    do begin
      @(negedge clk_i);
      taken = ready_o;
      @(posedge clk_i);
      #5;
    end while (!taken);
    valid_i = 1'b0;
  endtask

  // One-cycle clear pulse, valid stays low
  task automatic send_clear(input int idx);
    clear_i   = 1'b1;
    op_i      = ciph_op_e'(op_q[idx]);
    key_len_i = key_len_e'(len_q[idx]);
    @(posedge clk_i);
    #5;
    clear_i = 1'b0;
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // Random back-pressure, ready about 3 cycles in 4
  always @(posedge clk_i) begin
    logic b0;
    logic b1;
    #5;
    b0 = lfsr_next_bit();
    b1 = lfsr_next_bit();
    ready_i = b0 | b1;
  end

  initial begin
    lfsr_q       = 32'h8c20_707f;
    rst_ni       = 1'b0;
    clear_i      = 1'b0;
    valid_i      = 1'b0;
    op_i         = CIPH_FWD;
    key_len_i    = AES_128;
    round_i      = '0;
    key_i        = '0;
    other_errors = 0;
    read_stimulus();
    loaded = 1'b1;
    repeat (2) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (ready_o !== 1'b1 || valid_o !== 1'b0) begin
      $display("ERROR at time %0t: DUT not idle after reset", $time);
      other_errors++;
    end
    @(posedge clk_i);
    #5;
    // Clears follow requests at once, so earlier items are still in flight
    for (int i = 0; i < clr_q.size(); i++) begin
      if (clr_q[i]) begin
        send_clear(i);
      end else begin
        send_request(i);
      end
    end
    while (pending != 0) begin
      @(posedge clk_i);
    end
    // Extra cycles to catch duplicated outputs
    repeat (16) @(posedge clk_i);
    $display("Errors: %0d mismatches, %0d other failures", mismatches,
             seq_errors + other_errors);
    if (mismatches + seq_errors + other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog, budget scales with the stimulus length
  initial begin
    wait (loaded);
    repeat (clr_q.size() * 8 + 50) @(posedge clk_i);
    $display("ERROR at time %0t: timeout, outputs still missing: %0d", $time, pending);
    $display("Errors: %0d mismatches, %0d other failures", mismatches,
             seq_errors + other_errors + 1);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/key_expand_stimulus.txt
# Columns: clear op(0 fwd, 1 inv) len(0 AES-128, 1 AES-256) round key_in expected_out
# Windows are 8 words in FIPS-197 order, word 0 first, lower half then upper half
1 0 0 0 0 0
0 0 0 1 2b7e151628aed2a6abf7158809cf4f3c00000000000000000000000000000000 a0fafe1788542cb123a339392a6c76052b7e151628aed2a6abf7158809cf4f3c
0 0 0 2 a0fafe1788542cb123a339392a6c76052b7e151628aed2a6abf7158809cf4f3c f2c295f27a96b9435935807a7359f67fa0fafe1788542cb123a339392a6c7605
0 0 0 3 f2c295f27a96b9435935807a7359f67fa0fafe1788542cb123a339392a6c7605 3d80477d4716fe3e1e237e446d7a883bf2c295f27a96b9435935807a7359f67f
0 0 0 4 3d80477d4716fe3e1e237e446d7a883bf2c295f27a96b9435935807a7359f67f ef44a541a8525b7fb671253bdb0bad003d80477d4716fe3e1e237e446d7a883b
0 0 0 5 ef44a541a8525b7fb671253bdb0bad003d80477d4716fe3e1e237e446d7a883b d4d1c6f87c839d87caf2b8bc11f915bcef44a541a8525b7fb671253bdb0bad00
0 0 0 6 d4d1c6f87c839d87caf2b8bc11f915bcef44a541a8525b7fb671253bdb0bad00 6d88a37a110b3efddbf98641ca0093fdd4d1c6f87c839d87caf2b8bc11f915bc
0 0 0 7 6d88a37a110b3efddbf98641ca0093fdd4d1c6f87c839d87caf2b8bc11f915bc 4e54f70e5f5fc9f384a64fb24ea6dc4f6d88a37a110b3efddbf98641ca0093fd
0 0 0 8 4e54f70e5f5fc9f384a64fb24ea6dc4f6d88a37a110b3efddbf98641ca0093fd ead27321b58dbad2312bf5607f8d292f4e54f70e5f5fc9f384a64fb24ea6dc4f
0 0 0 9 ead27321b58dbad2312bf5607f8d292f4e54f70e5f5fc9f384a64fb24ea6dc4f ac7766f319fadc2128d12941575c006eead27321b58dbad2312bf5607f8d292f
0 0 0 a ac7766f319fadc2128d12941575c006eead27321b58dbad2312bf5607f8d292f d014f9a8c9ee2589e13f0cc8b6630ca6ac7766f319fadc2128d12941575c006e
1 1 0 0 0 0
0 1 0 a d014f9a8c9ee2589e13f0cc8b6630ca600000000000000000000000000000000 ac7766f319fadc2128d12941575c006ed014f9a8c9ee2589e13f0cc8b6630ca6
0 1 0 9 ac7766f319fadc2128d12941575c006ed014f9a8c9ee2589e13f0cc8b6630ca6 ead27321b58dbad2312bf5607f8d292fac7766f319fadc2128d12941575c006e
0 1 0 8 ead27321b58dbad2312bf5607f8d292fac7766f319fadc2128d12941575c006e 4e54f70e5f5fc9f384a64fb24ea6dc4fead27321b58dbad2312bf5607f8d292f
0 1 0 7 4e54f70e5f5fc9f384a64fb24ea6dc4fead27321b58dbad2312bf5607f8d292f 6d88a37a110b3efddbf98641ca0093fd4e54f70e5f5fc9f384a64fb24ea6dc4f
0 1 0 6 6d88a37a110b3efddbf98641ca0093fd4e54f70e5f5fc9f384a64fb24ea6dc4f d4d1c6f87c839d87caf2b8bc11f915bc6d88a37a110b3efddbf98641ca0093fd
0 1 0 5 d4d1c6f87c839d87caf2b8bc11f915bc6d88a37a110b3efddbf98641ca0093fd ef44a541a8525b7fb671253bdb0bad00d4d1c6f87c839d87caf2b8bc11f915bc
0 1 0 4 ef44a541a8525b7fb671253bdb0bad00d4d1c6f87c839d87caf2b8bc11f915bc 3d80477d4716fe3e1e237e446d7a883bef44a541a8525b7fb671253bdb0bad00
0 1 0 3 3d80477d4716fe3e1e237e446d7a883bef44a541a8525b7fb671253bdb0bad00 f2c295f27a96b9435935807a7359f67f3d80477d4716fe3e1e237e446d7a883b
0 1 0 2 f2c295f27a96b9435935807a7359f67f3d80477d4716fe3e1e237e446d7a883b a0fafe1788542cb123a339392a6c7605f2c295f27a96b9435935807a7359f67f
0 1 0 1 a0fafe1788542cb123a339392a6c7605f2c295f27a96b9435935807a7359f67f 2b7e151628aed2a6abf7158809cf4f3ca0fafe1788542cb123a339392a6c7605
1 0 1 0 0 0
0 0 1 0 1f352c073b6108d72d9810a30914dff4603deb1015ca71be2b73aef0857d7781 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4
0 0 1 1 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 1f352c073b6108d72d9810a30914dff49ba354118e6925afa51a8b5f2067fcde
0 0 1 2 1f352c073b6108d72d9810a30914dff49ba354118e6925afa51a8b5f2067fcde 9ba354118e6925afa51a8b5f2067fcdea8b09c1a93d194cdbe49846eb75d5b9a
0 0 1 3 9ba354118e6925afa51a8b5f2067fcdea8b09c1a93d194cdbe49846eb75d5b9a a8b09c1a93d194cdbe49846eb75d5b9ad59aecb85bf3c917fee94248de8ebe96
0 0 1 4 a8b09c1a93d194cdbe49846eb75d5b9ad59aecb85bf3c917fee94248de8ebe96 d59aecb85bf3c917fee94248de8ebe96b5a9328a2678a647983122292f6c79b3
0 0 1 5 d59aecb85bf3c917fee94248de8ebe96b5a9328a2678a647983122292f6c79b3 b5a9328a2678a647983122292f6c79b3812c81addadf48ba24360af2fab8b464
0 0 1 6 b5a9328a2678a647983122292f6c79b3812c81addadf48ba24360af2fab8b464 812c81addadf48ba24360af2fab8b46498c5bfc9bebd198e268c3ba709e04214
0 0 1 7 812c81addadf48ba24360af2fab8b46498c5bfc9bebd198e268c3ba709e04214 98c5bfc9bebd198e268c3ba709e0421468007bacb2df331696e939e46c518d80
1 1 1 0 0 0
0 1 1 d cafaaae3e4d59b349adf6acebd10190dfe4890d1e6188d0b046df344706c631e 749c47ab18501ddae2757e4f7401905acafaaae3e4d59b349adf6acebd10190d
0 1 1 c 749c47ab18501ddae2757e4f7401905acafaaae3e4d59b349adf6acebd10190d 5886ca5d2e2f31d77e0af1fa27cf73c3749c47ab18501ddae2757e4f7401905a
0 1 1 b 5886ca5d2e2f31d77e0af1fa27cf73c3749c47ab18501ddae2757e4f7401905a de1369676ccc5a71fa2563959674ee155886ca5d2e2f31d77e0af1fa27cf73c3
0 1 1 a de1369676ccc5a71fa2563959674ee155886ca5d2e2f31d77e0af1fa27cf73c3 c814e20476a9fb8a5025c02d59c58239de1369676ccc5a71fa2563959674ee15
0 1 1 9 c814e20476a9fb8a5025c02d59c58239de1369676ccc5a71fa2563959674ee15 68007bacb2df331696e939e46c518d80c814e20476a9fb8a5025c02d59c58239
0 1 1 8 68007bacb2df331696e939e46c518d80c814e20476a9fb8a5025c02d59c58239 98c5bfc9bebd198e268c3ba709e0421468007bacb2df331696e939e46c518d80

// File: build.f
+incdir+include
rtl/aes_key_pkg.sv
rtl/key_expand_decode.sv
rtl/key_expand_execute.sv
rtl/key_expand_result.sv
rtl/aes_key_expand_top.sv
test/key_expand_checker.sv
test/tb_key_expand.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator and run the key expansion testbench.
# Exit status is 0 only when the pass line appears in the output.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f \
    --top-module tb_key_expand -o sim_key_expand; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/sim_key_expand 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
  exit 0
else
  exit 1
fi
